// File: verif/cpu_vectors.txt
# test <name> <cycle budget>, mem <word addr> <word>, exp <store addr> <store data>
# end closes a test, addresses and words in hex
test ldi_store 40
mem 0000 02b3c089
mem 0001 0091a489
mem 0002 00020109
mem 0003 00004407
mem 0004 0000000d
mem 0005 00004407
exp 0040 12345678
end
test alu 100
mem 0000 07fff809
mem 0001 07fffc09
mem 0002 00000889
mem 0003 00022100
mem 0004 00004807
mem 0005 00042206
mem 0006 00009007
mem 0007 00051284
mem 0008 0000b407
mem 0009 00060701
mem 000a 0000d807
mem 000b 00072385
mem 000c 0000fc07
mem 000d 00033182
mem 000e 00006c07
mem 000f 0001c483
mem 0010 00002407
mem 0011 0000a009
mem 0012 0000080c
mem 0013 00002407
mem 0014 0000000c
mem 0015 00006c07
mem 0016 0000000d
exp 0000 00000000
exp ffff 7fffffff
exp 0000 80000000
exp 0002 00000002
exp fffe fffffffe
exp 0001 00000001
exp 0003 00000003
exp 0001 00000001
end
# registers g and h were written by the previous test
test halt_reset 60
mem 0000 00038009
mem 0001 00001807
mem 0002 0000007f
mem 0003 00001c07
mem 0004 0000000d
exp 0070 00000000
end
test load 60
mem 0000 00018009
mem 0001 00018889
mem 0002 0000010a
mem 0003 0000218a
mem 0004 00046a00
mem 0005 00020289
mem 0006 0000b007
mem 0007 0000000d
mem 0030 00000005
mem 0031 00000007
exp 0040 0000000c
end
test loop 100
mem 0000 00000889
mem 0001 00001909
mem 0002 00030189
mem 0003 00003209
mem 0004 0000800b
mem 0005 00006407
mem 0006 00003a89
mem 0007 00006007
mem 0008 00062000
mem 0009 00074008
mem 000a 0000bc0c
mem 000b 0000000d
exp 0060 00000000
exp 0060 00000001
exp 0060 00000002
end

// File: vlog.f
hw/cpu_pkg.sv
hw/reg_file.sv
hw/alu.sv
hw/cpu_control.sv
hw/cpu.sv
verif/tb_mem_model.sv
verif/tb_cpu.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f vlog.f \
    --top-module tb_cpu \
    -o tb_cpu_sim

output=$(./obj_dir/tb_cpu_sim)
echo "$output"

if grep -qF '** PASS **' <<< "$output"; then
    exit 0
fi
exit 1

// File: verif/tb_cpu.sv
`default_nettype none

module tb_cpu;

    localparam int max_tests   = 16;
    localparam int reset_cycles = 4;
    localparam int settle_cycles = 8;   // Extra cycles after halt to catch stray stores

    logic                           clock;
    logic                           rst_n;
    logic [cpu_pkg::data_width-1:0] rdata;
    cpu_pkg::mem_req_t              mem;
    logic                           halted;
    logic                           clear;
    logic                           load_en;
    logic [cpu_pkg::addr_width-1:0] load_addr;
    logic [cpu_pkg::data_width-1:0] load_data;

    string                          test_name [max_tests];
    int                             test_budget [max_tests];
    int                             word_first [max_tests];
    int                             word_count [max_tests];
    int                             exp_first [max_tests];
    int                             exp_count [max_tests];
    logic [cpu_pkg::addr_width-1:0] word_addr [$];
    logic [cpu_pkg::data_width-1:0] word_data [$];
    logic [cpu_pkg::addr_width-1:0] exp_addr [$];
    logic [cpu_pkg::data_width-1:0] exp_data [$];
    int                             n_tests;
    int                             pass_count;
    int                             fail_count;
    longint                         watch_cycles;

    cpu i_cpu (
        .clock  (clock),
        .rst_n  (rst_n),
        .rdata  (rdata),
        .mem    (mem),
        .halted (halted)
    );

    tb_mem_model i_mem (
        .clock     (clock),
        .mem       (mem),
        .clear     (clear),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .rdata     (rdata)
    );

    always #4 clock = ~clock;

    task automatic read_vectors(output int bad);
        int    fd;
        int    code;
        string kind;
        string line;
        int    budget;
        logic [cpu_pkg::data_width-1:0] a;
        logic [cpu_pkg::data_width-1:0] d;
        bad = 0;
        fd = $fopen("verif/cpu_vectors.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the vector file");
            bad = 1;
            return;
        end
        while (!$feof(fd))
        begin
            code = $fscanf(fd, "%s", kind);
            if (code != 1)
                break;
            if (kind == "#")
                code = $fgets(line, fd);
            else if (kind == "test")
            begin
                code = $fscanf(fd, "%s %d", test_name[n_tests], budget);
                test_budget[n_tests] = budget;
                word_first[n_tests] = word_addr.size();
                word_count[n_tests] = 0;
                exp_first[n_tests] = exp_addr.size();
                exp_count[n_tests] = 0;
            end
            else if (kind == "mem" || kind == "exp")
            begin
                code = $fscanf(fd, "%h %h", a, d);
                if (kind == "mem")
                begin
                    word_addr.push_back(a[cpu_pkg::addr_width-1:0]);
                    word_data.push_back(d);
                    word_count[n_tests]++;
                end
                else
                begin
                    exp_addr.push_back(a[cpu_pkg::addr_width-1:0]);
                    exp_data.push_back(d);
                    exp_count[n_tests]++;
                end
            end
            else if (kind == "end")
                n_tests++;
            else
            begin
                $display("unknown record kind %s in the vector file", kind);
                bad = 1;
            end
        end
        $fclose(fd);
    endtask

    task automatic run_test(input int t);
        int errs;
        int cycles;
        int got;
        logic [cpu_pkg::addr_width+cpu_pkg::data_width-1:0] rec;
        errs = 0;
        @(negedge clock);
        rst_n = 1'b0;
        clear = 1'b1;
        @(negedge clock);
        clear = 1'b0;
        for (int k = 0; k < word_count[t]; k++)
        begin
            load_en = 1'b1;
            load_addr = word_addr[word_first[t] + k];
            load_data = word_data[word_first[t] + k];
            @(negedge clock);
        end
        load_en = 1'b0;
        repeat (reset_cycles) @(negedge clock);
        rst_n = 1'b1;
        cycles = 0;
        while (!halted && cycles < test_budget[t])
        begin
            @(negedge clock);
            cycles++;
        end
        assert (halted)
        else
        begin
            $display("%s: core did not halt within %0d cycles", test_name[t], test_budget[t]);
            errs++;
        end
        repeat (settle_cycles) @(negedge clock);
        got = i_mem.stores.size();
        assert (got == exp_count[t])
        else
        begin
            $display("%s: saw %0d stores, expected %0d", test_name[t], got, exp_count[t]);
            errs++;
        end
        for (int k = 0; k < got && k < exp_count[t]; k++)
        begin
            rec = i_mem.stores[k];
            assert (rec == {exp_addr[exp_first[t] + k], exp_data[exp_first[t] + k]})
            else
            begin
                $display("mismatch at %0t: %s store %0d got %h:%h expected %h:%h", $time,
                         test_name[t], k, rec[47:32], rec[31:0],
                         exp_addr[exp_first[t] + k], exp_data[exp_first[t] + k]);
                errs++;
            end
        end
        if (errs == 0)
            pass_count++;
        else
            fail_count++;
        $display("test %-12s %s after %0d cycles, %0d errors", test_name[t],
                 (errs == 0) ? "passed" : "failed", cycles, errs);
    endtask

    initial
    begin
        int bad;
        clock = 1'b0;
        rst_n = 1'b0;
        clear = 1'b0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        n_tests = 0;
        pass_count = 0;
        fail_count = 0;
        watch_cycles = 0;
        read_vectors(bad);
        if (bad != 0)
            fail_count++;
        for (int t = 0; t < n_tests; t++)
        begin
            watch_cycles += test_budget[t] + word_count[t] + reset_cycles + settle_cycles + 4;
        end
        watch_cycles += 16;
        for (int t = 0; t < n_tests; t++)
        begin
            run_test(t);
        end
        $display("%0d tests passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && n_tests > 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    // Limit follows the cycle budgets read from the vectors
    initial
    begin
        wait (watch_cycles > 0);
        #(watch_cycles * 8);
        $display("timeout, the run took longer than the summed cycle budgets");
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/tb_mem_model.sv
`default_nettype none

module tb_mem_model (
    input  logic                           clock,
    input  cpu_pkg::mem_req_t              mem,
    input  logic                           clear,
    input  logic                           load_en,
    input  logic [cpu_pkg::addr_width-1:0] load_addr,
    input  logic [cpu_pkg::data_width-1:0] load_data,
    output logic [cpu_pkg::data_width-1:0] rdata
);

    logic [cpu_pkg::data_width-1:0] words [2**cpu_pkg::addr_width];
    logic [cpu_pkg::addr_width+cpu_pkg::data_width-1:0] stores [$];   // {addr, data} per store

    always @(posedge clock)
    begin
        if (clear)
        begin
            for (int i = 0; i < 2**cpu_pkg::addr_width; i++)
            begin
                words[i[cpu_pkg::addr_width-1:0]] <= '0;
            end
            stores.delete();
        end
        else if (load_en)
        begin
            words[load_addr] <= load_data;
        end
        if (mem.rd)
            rdata <= words[mem.addr];   // Valid for the whole next cycle
        if (mem.wr)
        begin
            words[mem.addr] <= mem.wdata;
            stores.push_back({mem.addr, mem.wdata});
        end
    end

endmodule

`default_nettype wire

// File: hw/cpu.sv
`default_nettype none

module cpu (
    input  logic                           clock,
    input  logic                           rst_n,
    input  logic [cpu_pkg::data_width-1:0] rdata,
    output cpu_pkg::mem_req_t              mem,
    output logic                           halted
);

    logic [cpu_pkg::reg_idx_width-1:0] ra_idx;
    logic [cpu_pkg::reg_idx_width-1:0] rb_idx;
    logic [cpu_pkg::data_width-1:0]    ra_data;
    logic [cpu_pkg::data_width-1:0]    rb_data;
    logic                              ra_flag;
    logic                              rb_flag;
    cpu_pkg::alu_req_t                 alu_req;
    cpu_pkg::alu_rsp_t                 alu_rsp;
    cpu_pkg::rf_wr_t                   rf_wr;

    cpu_control i_control (
        .clock   (clock),
        .rst_n   (rst_n),
        .rdata   (rdata),
        .ra_data (ra_data),
        .rb_data (rb_data),
        .ra_flag (ra_flag),
        .rb_flag (rb_flag),
        .alu_rsp (alu_rsp),
        .ra_idx  (ra_idx),
        .rb_idx  (rb_idx),
        .alu_req (alu_req),
        .rf_wr   (rf_wr),
        .mem     (mem),
        .halted  (halted)
    );

    reg_file i_reg_file (
        .clock   (clock),
        .rst_n   (rst_n),
        .ra_idx  (ra_idx),
        .rb_idx  (rb_idx),
        .wr      (rf_wr),
        .ra_data (ra_data),
        .rb_data (rb_data),
        .ra_flag (ra_flag),
        .rb_flag (rb_flag)
    );

    alu i_alu (
        .req (alu_req),
        .rsp (alu_rsp)
    );

endmodule

`default_nettype wire

// File: hw/cpu_control.sv
`default_nettype none

module cpu_control (
    input  logic                              clock,
    input  logic                              rst_n,
    input  logic [cpu_pkg::data_width-1:0]    rdata,
    input  logic [cpu_pkg::data_width-1:0]    ra_data,
    input  logic [cpu_pkg::data_width-1:0]    rb_data,
    input  logic                              ra_flag,
    input  logic                              rb_flag,
    input  cpu_pkg::alu_rsp_t                 alu_rsp,
    output logic [cpu_pkg::reg_idx_width-1:0] ra_idx,
    output logic [cpu_pkg::reg_idx_width-1:0] rb_idx,
    output cpu_pkg::alu_req_t                 alu_req,
    output cpu_pkg::rf_wr_t                   rf_wr,
    output cpu_pkg::mem_req_t                 mem,
    output logic                              halted
);

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_load_wb,
        st_halted
    } state_t;

    state_t                          state;
    state_t                          state_next;
    logic                            run;      // Low for the first cycle out of reset
    logic [cpu_pkg::addr_width-1:0]  pc;
    cpu_pkg::instr_u                 ir;
    cpu_pkg::opcode_e                op;
    logic                            branch;

    function automatic logic known_op(input logic [cpu_pkg::opcode_width-1:0] code);
        logic ok;
        case (code)
            cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and, cpu_pkg::op_or,
            cpu_pkg::op_xor, cpu_pkg::op_shl, cpu_pkg::op_shr, cpu_pkg::op_st,
            cpu_pkg::op_cmplt, cpu_pkg::op_ldi, cpu_pkg::op_ld, cpu_pkg::op_jmp,
            cpu_pkg::op_brf, cpu_pkg::op_halt: ok = 1'b1;
            default: ok = 1'b0;
        endcase
        return ok;
    endfunction

    assign op     = cpu_pkg::opcode_e'(ir.r.opcode);
    assign ra_idx = (op == cpu_pkg::op_ldi) ? ir.i.rd : ir.r.ra;   // ldi reads its own rd
    assign rb_idx = ir.r.rb;
    assign branch = (op == cpu_pkg::op_jmp || op == cpu_pkg::op_brf) && alu_rsp.flag;
    assign halted = (state == st_halted);

    always_comb
    begin
        alu_req.op = op;
        alu_req.a = ra_data;
        alu_req.b = rb_data;
        alu_req.flag_a = ra_flag;
        alu_req.flag_b = rb_flag;
        alu_req.imm = ir.i.imm;
        alu_req.hi = ir.i.hi;
        alu_req.rd_value = ra_data;
    end

    always_comb
    begin
        mem = '0;
        case (state)
            st_fetch:
            begin
                mem.rd = run;
                mem.addr = pc;
            end
            st_execute:
            begin
                mem.addr = rb_data[cpu_pkg::addr_width-1:0];
                mem.wdata = ra_data;
                mem.rd = (op == cpu_pkg::op_ld);
                mem.wr = (op == cpu_pkg::op_st);
            end
            default:
            begin
                mem.addr = pc;
            end
        endcase
    end

    always_comb
    begin
        rf_wr = '0;
        rf_wr.reg_idx = ir.r.rd;
        rf_wr.flag_idx = ir.r.fd;
        rf_wr.flag_val = alu_rsp.flag;
        rf_wr.data = alu_rsp.result;
        if (state == st_execute)
        begin
            rf_wr.reg_en = alu_rsp.res_valid;
            rf_wr.flag_en = alu_rsp.flag_valid;
        end
        else if (state == st_load_wb)
        begin
            rf_wr.reg_en = 1'b1;
            rf_wr.data = rdata;   // Word from the load address
        end
    end

    always_comb
    begin
        state_next = state;
        case (state)
            st_fetch:   state_next = run ? st_decode : st_fetch;
            st_decode:  state_next = st_execute;
            st_execute:
            begin
                if (op == cpu_pkg::op_halt || !known_op(ir.r.opcode))
                    state_next = st_halted;
                else if (op == cpu_pkg::op_ld)
                    state_next = st_load_wb;
                else
                    state_next = st_fetch;
            end
            st_load_wb: state_next = st_fetch;
            default:    state_next = st_halted;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= st_fetch;
            run <= 1'b0;
            pc <= '0;
        end
        else
        begin
            state <= state_next;
            run <= 1'b1;
            if (state == st_execute)
                pc <= branch ? rb_data[cpu_pkg::addr_width-1:0] : pc + 1'b1;
        end
    end

    always_ff @(posedge clock)
    begin
        if (state == st_decode)
            ir <= rdata;   // Fetched word is on rdata during decode
    end

    a_strobes_exclusive: assert property (
        @(posedge clock) disable iff (!rst_n)
        !(mem.rd && mem.wr)
    ) else $error("read and write strobes high together");

    a_quiet_when_halted: assert property (
        @(posedge clock) disable iff (!rst_n)
        halted |-> (!mem.rd && !mem.wr)
    ) else $error("memory strobe raised while halted");

    a_unknown_op_halts: assert property (
        @(posedge clock) disable iff (!rst_n)
        (state == st_execute && !known_op(ir.r.opcode)) |=> halted
    ) else $error("unknown opcode did not halt the core");

endmodule

`default_nettype wire

// File: hw/alu.sv
`default_nettype none

module alu (
    input  cpu_pkg::alu_req_t req,
    output cpu_pkg::alu_rsp_t rsp
);

    logic [cpu_pkg::data_width:0]   sum;
    logic [cpu_pkg::data_width:0]   diff;
    logic [cpu_pkg::data_width:0]   shl_w;
    logic [cpu_pkg::data_width:0]   shr_w;
    logic [4:0]                     shamt;
    logic [cpu_pkg::data_width-1:0] logic_res;

    assign shamt = req.b[4:0];
    assign sum   = {1'b0, req.a} + {1'b0, req.b};
    assign diff  = {1'b0, req.a} - {1'b0, req.b};   // Top bit is the borrow
    assign shl_w = {1'b0, req.a} << shamt;
    assign shr_w = {req.a, 1'b0} >> shamt;          // Low bit catches the last one out

    always_comb
    begin
        rsp = '0;
        logic_res = '0;
        case (req.op)
            cpu_pkg::op_add:
            begin
                {rsp.flag, rsp.result} = sum;
                rsp.res_valid = 1'b1;
                rsp.flag_valid = 1'b1;
            end
            cpu_pkg::op_sub:
            begin
                {rsp.flag, rsp.result} = diff;
                rsp.res_valid = 1'b1;
                rsp.flag_valid = 1'b1;
            end
            cpu_pkg::op_and, cpu_pkg::op_or, cpu_pkg::op_xor:
            begin
                if (req.op == cpu_pkg::op_and)
                    logic_res = req.a & req.b;
                else if (req.op == cpu_pkg::op_or)
                    logic_res = req.a | req.b;
                else
                    logic_res = req.a ^ req.b;
                rsp.result = logic_res;
                rsp.flag = |logic_res;   // Nonzero
                rsp.res_valid = 1'b1;
                rsp.flag_valid = 1'b1;
            end
            cpu_pkg::op_shl:
            begin
                {rsp.flag, rsp.result} = shl_w;
                rsp.res_valid = 1'b1;
                rsp.flag_valid = 1'b1;
            end
            cpu_pkg::op_shr:
            begin
                {rsp.result, rsp.flag} = shr_w;
                rsp.res_valid = 1'b1;
                rsp.flag_valid = 1'b1;
            end
            cpu_pkg::op_cmplt:
            begin
                rsp.flag = req.a < req.b;   // Unsigned
                rsp.flag_valid = 1'b1;
            end
            cpu_pkg::op_ldi:
            begin
                if (req.hi)
                    rsp.result = {req.imm, req.rd_value[cpu_pkg::imm_width-1:0]};
                else
                    rsp.result = {req.rd_value[cpu_pkg::data_width-1:cpu_pkg::imm_width],
                                  req.imm};
                rsp.res_valid = 1'b1;
            end
            cpu_pkg::op_jmp: rsp.flag = 1'b1;           // Always taken
            cpu_pkg::op_brf: rsp.flag = req.flag_a;     // Taken on ra's flag
            default:         rsp.flag = req.flag_b;     // Nothing written
        endcase
    end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`default_nettype none

module reg_file (
    input  logic                                 clock,
    input  logic                                 rst_n,
    input  logic [cpu_pkg::reg_idx_width-1:0]    ra_idx,
    input  logic [cpu_pkg::reg_idx_width-1:0]    rb_idx,
    input  cpu_pkg::rf_wr_t                      wr,
    output logic [cpu_pkg::data_width-1:0]       ra_data,
    output logic [cpu_pkg::data_width-1:0]       rb_data,
    output logic                                 ra_flag,
    output logic                                 rb_flag
);

    logic [cpu_pkg::data_width-1:0] regs [cpu_pkg::reg_count];
    logic [cpu_pkg::reg_count-1:0]  flags;

    assign ra_data = regs[ra_idx];
    assign rb_data = regs[rb_idx];
    assign ra_flag = flags[ra_idx];
    assign rb_flag = flags[rb_idx];

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < cpu_pkg::reg_count; i++)
            begin
                regs[i] <= '0;
            end
            flags <= '0;
        end
        else
        begin
            if (wr.reg_en)
                regs[wr.reg_idx] <= wr.data;
            if (wr.flag_en)
                flags[wr.flag_idx] <= wr.flag_val;   // May differ from reg_idx
        end
    end

    // At most one write per instruction, and no instruction is shorter than 3 cycles
    a_no_back_to_back_write: assert property (
        @(posedge clock) disable iff (!rst_n)
        (wr.reg_en || wr.flag_en) |=> !(wr.reg_en || wr.flag_en)
    ) else $error("register file written in two consecutive cycles");

endmodule

`default_nettype wire

// File: hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int data_width    = 32;
    localparam int addr_width    = 16;
    localparam int reg_count     = 8;
    localparam int reg_idx_width = 3;
    localparam int opcode_width  = 7;
    localparam int imm_width     = 16;

    // Store keeps the old encoding 7
    typedef enum logic [opcode_width-1:0] {
        op_add   = 7'd0,
        op_sub   = 7'd1,
        op_and   = 7'd2,
        op_or    = 7'd3,
        op_xor   = 7'd4,
        op_shl   = 7'd5,
        op_shr   = 7'd6,
        op_st    = 7'd7,
        op_cmplt = 7'd8,
        op_ldi   = 7'd9,
        op_ld    = 7'd10,
        op_jmp   = 7'd11,
        op_brf   = 7'd12,
        op_halt  = 7'd13
    } opcode_e;

    typedef struct packed {
        logic [12:0]              spare;
        logic [reg_idx_width-1:0] fd;      // Flag destination
        logic [reg_idx_width-1:0] rb;
        logic [reg_idx_width-1:0] ra;
        logic [reg_idx_width-1:0] rd;
        logic [opcode_width-1:0]  opcode;
    } instr_r_t;

    typedef struct packed {
        logic [4:0]               spare;
        logic [imm_width-1:0]     imm;
        logic                     hi;      // Upper half select
        logic [reg_idx_width-1:0] rd;
        logic [opcode_width-1:0]  opcode;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    typedef struct packed {
        opcode_e               op;
        logic [data_width-1:0] a;
        logic [data_width-1:0] b;
        logic                  flag_a;
        logic                  flag_b;
        logic [imm_width-1:0]  imm;
        logic                  hi;
        logic [data_width-1:0] rd_value;   // Old rd contents for ldi
    } alu_req_t;

    typedef struct packed {
        logic [data_width-1:0] result;
        logic                  flag;
        logic                  res_valid;
        logic                  flag_valid;
    } alu_rsp_t;

    typedef struct packed {
        logic                  rd;
        logic                  wr;
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                     reg_en;
        logic [reg_idx_width-1:0] reg_idx;
        logic [data_width-1:0]    data;
        logic                     flag_en;
        logic [reg_idx_width-1:0] flag_idx;
        logic                     flag_val;
    } rf_wr_t;

endpackage

`default_nettype wire
